// File: source/od_defs.svh
/* object dictionary constants */
`ifndef OD_DEFS_SVH
`define OD_DEFS_SVH

`define OD_ADDR_W                 12
`define OD_ID_W                   16
`define OD_ADDR_INVALID           12'hfff
`define OD_DICT_SPAN              12'd144     // whole dictionary length

// up-direction link ranges, 1000 ids each
`define OD_LINK_RANGE_SPAN        16'd1000
`define OD_LINK_LOCAL_UP_START    16'd6000
`define OD_LINK_NET_UP_START      16'd7000
`define OD_DEV_PROP_UP_START      16'd8000
`define OD_LINK_LOCAL_UP_BASE     12'h100
`define OD_LINK_NET_UP_BASE       12'h300
`define OD_DEV_PROP_UP_BASE       12'h400

// fixed object bases in dictionary memory
`define OD_BASE_WHOLE             12'd0
`define OD_BASE_HEADER            12'd0
`define OD_BASE_DEV_DESC          12'd2
`define OD_BASE_CLK_SYNC          12'd54
`define OD_BASE_MAX_RSP           12'd75
`define OD_BASE_SCHED             12'd79
`define OD_BASE_APP_INFO          12'd103
`define OD_BASE_DOMAIN_HDR        12'd113
`define OD_BASE_LOCAL_UP_HDR      12'd118
`define OD_BASE_NET_UP_HDR        12'd123
`define OD_BASE_DEV_PROP_UP_HDR   12'd128

`endif

// File: source/od_pkg.sv
/* object dictionary types */
`default_nettype none

`include "od_defs.svh"

package od_pkg;

	typedef logic [`OD_ADDR_W-1:0] od_addr_t;   // addresses and lengths
	typedef logic [`OD_ID_W-1:0] od_id_t;       // object ids and subindices

	// one class per kept object, ids in comments
	typedef enum logic [3:0] {
		WHOLE_DICT,         // 0
		DICT_HEADER,        // 1
		DEV_DESC,           // 2
		CLOCK_SYNC,         // 3
		MAX_RSP_TIME,       // 4
		SCHED_MGMT,         // 5
		DEV_APP_INFO,       // 6
		DOMAIN_APP_HDR,     // 9
		LOCAL_UP_HDR,       // 10
		NET_UP_HDR,         // 11
		DEV_PROP_UP_HDR,    // 12
		// link object ranges
		LINK_LOCAL_UP,      // 6000..6999
		LINK_NET_UP,        // 7000..7999
		DEV_PROP_UP,        // 8000..8999
		UNKNOWN
	} od_class_e;

endpackage

`default_nettype wire

// File: source/od_obj_classify.sv
/* object id classifier */
`timescale 1ns/100ps
`default_nettype none

`include "od_defs.svh"

module od_obj_classify
(
	input  od_pkg::od_id_t    i_dobjid,
	output od_pkg::od_class_e o_class,
	output od_pkg::od_id_t    o_index     // position inside a link range
);

	logic in_local_up;
	logic in_net_up;
	logic in_dev_prop_up;

	// range bounds, upper end exclusive
	assign in_local_up = (i_dobjid >= `OD_LINK_LOCAL_UP_START) &&
		(i_dobjid < `OD_LINK_LOCAL_UP_START + `OD_LINK_RANGE_SPAN);
	assign in_net_up = (i_dobjid >= `OD_LINK_NET_UP_START) &&
		(i_dobjid < `OD_LINK_NET_UP_START + `OD_LINK_RANGE_SPAN);
	assign in_dev_prop_up = (i_dobjid >= `OD_DEV_PROP_UP_START) &&
		(i_dobjid < `OD_DEV_PROP_UP_START + `OD_LINK_RANGE_SPAN);

	always_comb
	begin
		o_class = od_pkg::UNKNOWN;
		o_index = '0;
		if (in_local_up)
		begin
			o_class = od_pkg::LINK_LOCAL_UP;
			o_index = i_dobjid - `OD_LINK_LOCAL_UP_START;
		end
		else if (in_net_up)
		begin
			o_class = od_pkg::LINK_NET_UP;
			o_index = i_dobjid - `OD_LINK_NET_UP_START;
		end
		else if (in_dev_prop_up)
		begin
			o_class = od_pkg::DEV_PROP_UP;
			o_index = i_dobjid - `OD_DEV_PROP_UP_START;
		end
		else
		begin
			case (i_dobjid)
				`OD_ID_W'd0:  o_class = od_pkg::WHOLE_DICT;
				`OD_ID_W'd1:  o_class = od_pkg::DICT_HEADER;
				`OD_ID_W'd2:  o_class = od_pkg::DEV_DESC;
				`OD_ID_W'd3:  o_class = od_pkg::CLOCK_SYNC;
				`OD_ID_W'd4:  o_class = od_pkg::MAX_RSP_TIME;
				`OD_ID_W'd5:  o_class = od_pkg::SCHED_MGMT;
				`OD_ID_W'd6:  o_class = od_pkg::DEV_APP_INFO;
				`OD_ID_W'd9:  o_class = od_pkg::DOMAIN_APP_HDR;
				`OD_ID_W'd10: o_class = od_pkg::LOCAL_UP_HDR;
				`OD_ID_W'd11: o_class = od_pkg::NET_UP_HDR;
				`OD_ID_W'd12: o_class = od_pkg::DEV_PROP_UP_HDR;
				default:      o_class = od_pkg::UNKNOWN;   // 7, 8, down side, gaps
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/od_base_addr.sv
/* object base address stage */
`timescale 1ns/100ps
`default_nettype none

`include "od_defs.svh"

module od_base_addr
(
	input  wire               i_clk,
	input  wire               i_rst_n,
	input  od_pkg::od_class_e i_class,
	input  od_pkg::od_id_t    i_index,
	output od_pkg::od_addr_t  o_base,
	output logic              o_obj_known
);

	od_pkg::od_addr_t idx;
	od_pkg::od_addr_t base_nxt;
	logic             known_nxt;

	assign idx = i_index[`OD_ADDR_W-1:0];   // upper bits drop out after scaling anyway

	always_comb
	begin
		known_nxt = 1'b1;
		case (i_class)
			od_pkg::WHOLE_DICT:      base_nxt = `OD_BASE_WHOLE;
			od_pkg::DICT_HEADER:     base_nxt = `OD_BASE_HEADER;
			od_pkg::DEV_DESC:        base_nxt = `OD_BASE_DEV_DESC;
			od_pkg::CLOCK_SYNC:      base_nxt = `OD_BASE_CLK_SYNC;
			od_pkg::MAX_RSP_TIME:    base_nxt = `OD_BASE_MAX_RSP;
			od_pkg::SCHED_MGMT:      base_nxt = `OD_BASE_SCHED;
			od_pkg::DEV_APP_INFO:    base_nxt = `OD_BASE_APP_INFO;
			od_pkg::DOMAIN_APP_HDR:  base_nxt = `OD_BASE_DOMAIN_HDR;
			od_pkg::LOCAL_UP_HDR:    base_nxt = `OD_BASE_LOCAL_UP_HDR;
			od_pkg::NET_UP_HDR:      base_nxt = `OD_BASE_NET_UP_HDR;
			od_pkg::DEV_PROP_UP_HDR: base_nxt = `OD_BASE_DEV_PROP_UP_HDR;
			// link objects are 8, 4 and 9 bytes long
			od_pkg::LINK_LOCAL_UP:
				base_nxt = (idx << 3) + `OD_LINK_LOCAL_UP_BASE;
			od_pkg::LINK_NET_UP:
				base_nxt = (idx << 2) + `OD_LINK_NET_UP_BASE;
			od_pkg::DEV_PROP_UP:
				base_nxt = (idx << 3) + idx + `OD_DEV_PROP_UP_BASE;
			default:
			begin
				base_nxt = `OD_ADDR_INVALID;
				known_nxt = 1'b0;
			end
		endcase
	end

	// idle value merges to a clean zero result
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_base <= '0;
			o_obj_known <= 1'b1;
		end
		else
		begin
			o_base <= base_nxt;
			o_obj_known <= known_nxt;
		end
	end

endmodule

`default_nettype wire

// File: source/od_entry_table.sv
/* subindex offset and length tables */
`timescale 1ns/100ps
`default_nettype none

`include "od_defs.svh"

module od_entry_table
(
	input  wire               i_clk,
	input  wire               i_rst_n,
	input  od_pkg::od_class_e i_class,
	input  od_pkg::od_id_t    i_subidx,
	input  od_pkg::od_id_t    i_frt_linknum_up,
	input  od_pkg::od_id_t    i_frt_linknum_net_up,
	input  od_pkg::od_id_t    i_device_num_up,
	output od_pkg::od_addr_t  o_offset,
	output od_pkg::od_addr_t  o_len,
	output logic              o_sub_ok
);

	od_pkg::od_addr_t ent_off;
	od_pkg::od_addr_t ent_len;
	logic             ent_ok;
	od_pkg::od_id_t   ones_cnt;   // entry count of a table with 1-byte entries only

	always_comb
	begin
		ent_off = '0;
		ent_len = '0;
		ent_ok = 1'b1;
		ones_cnt = '0;
		case (i_class)
			od_pkg::WHOLE_DICT:
			begin
				if (i_subidx == '0)
					ent_len = `OD_DICT_SPAN;
				else
					ent_ok = 1'b0;
			end
			od_pkg::DICT_HEADER, od_pkg::DEV_APP_INFO: ones_cnt = `OD_ID_W'd2;
			od_pkg::DOMAIN_APP_HDR, od_pkg::LOCAL_UP_HDR, od_pkg::NET_UP_HDR:
				ones_cnt = `OD_ID_W'd5;
			od_pkg::DEV_PROP_UP_HDR: ones_cnt = `OD_ID_W'd3;
			od_pkg::LINK_NET_UP:     ones_cnt = `OD_ID_W'd4;
			od_pkg::DEV_DESC:
				case (i_subidx)
					`OD_ID_W'd0:  {ent_off, ent_len} = {`OD_ADDR_W'd0, `OD_ADDR_W'd52};
					`OD_ID_W'd1:  {ent_off, ent_len} = {`OD_ADDR_W'd0, `OD_ADDR_W'd1};
					`OD_ID_W'd2:  {ent_off, ent_len} = {`OD_ADDR_W'd1, `OD_ADDR_W'd1};
					`OD_ID_W'd3:  {ent_off, ent_len} = {`OD_ADDR_W'd2, `OD_ADDR_W'd16};
					`OD_ID_W'd4:  {ent_off, ent_len} = {`OD_ADDR_W'd18, `OD_ADDR_W'd16};
					`OD_ID_W'd5:  {ent_off, ent_len} = {`OD_ADDR_W'd34, `OD_ADDR_W'd2};
					`OD_ID_W'd6:  {ent_off, ent_len} = {`OD_ADDR_W'd36, `OD_ADDR_W'd2};
					`OD_ID_W'd7:  {ent_off, ent_len} = {`OD_ADDR_W'd38, `OD_ADDR_W'd2};
					`OD_ID_W'd8:  {ent_off, ent_len} = {`OD_ADDR_W'd40, `OD_ADDR_W'd2};
					`OD_ID_W'd9:  {ent_off, ent_len} = {`OD_ADDR_W'd42, `OD_ADDR_W'd3};
					`OD_ID_W'd10: {ent_off, ent_len} = {`OD_ADDR_W'd45, `OD_ADDR_W'd1};
					`OD_ID_W'd11: {ent_off, ent_len} = {`OD_ADDR_W'd46, `OD_ADDR_W'd2};
					`OD_ID_W'd12: {ent_off, ent_len} = {`OD_ADDR_W'd48, `OD_ADDR_W'd1};
					`OD_ID_W'd13: {ent_off, ent_len} = {`OD_ADDR_W'd49, `OD_ADDR_W'd1};
					`OD_ID_W'd14: {ent_off, ent_len} = {`OD_ADDR_W'd50, `OD_ADDR_W'd1};
					`OD_ID_W'd15: {ent_off, ent_len} = {`OD_ADDR_W'd51, `OD_ADDR_W'd1};
					default:      ent_ok = 1'b0;
				endcase
			od_pkg::CLOCK_SYNC:
				case (i_subidx)
					`OD_ID_W'd0:  {ent_off, ent_len} = {`OD_ADDR_W'd0, `OD_ADDR_W'd21};
					`OD_ID_W'd1:  {ent_off, ent_len} = {`OD_ADDR_W'd0, `OD_ADDR_W'd1};
					`OD_ID_W'd2:  {ent_off, ent_len} = {`OD_ADDR_W'd1, `OD_ADDR_W'd1};
					`OD_ID_W'd3:  {ent_off, ent_len} = {`OD_ADDR_W'd2, `OD_ADDR_W'd2};
					`OD_ID_W'd4:  {ent_off, ent_len} = {`OD_ADDR_W'd4, `OD_ADDR_W'd2};
					`OD_ID_W'd5:  {ent_off, ent_len} = {`OD_ADDR_W'd6, `OD_ADDR_W'd2};
					`OD_ID_W'd6:  {ent_off, ent_len} = {`OD_ADDR_W'd8, `OD_ADDR_W'd2};
					`OD_ID_W'd7:  {ent_off, ent_len} = {`OD_ADDR_W'd10, `OD_ADDR_W'd2};
					`OD_ID_W'd8:  {ent_off, ent_len} = {`OD_ADDR_W'd12, `OD_ADDR_W'd2};
					`OD_ID_W'd9:  {ent_off, ent_len} = {`OD_ADDR_W'd14, `OD_ADDR_W'd4};
					`OD_ID_W'd10: {ent_off, ent_len} = {`OD_ADDR_W'd18, `OD_ADDR_W'd3};
					default:      ent_ok = 1'b0;
				endcase
			od_pkg::MAX_RSP_TIME:
				case (i_subidx)
					`OD_ID_W'd0: {ent_off, ent_len} = {`OD_ADDR_W'd0, `OD_ADDR_W'd4};
					`OD_ID_W'd1: {ent_off, ent_len} = {`OD_ADDR_W'd0, `OD_ADDR_W'd1};
					`OD_ID_W'd2: {ent_off, ent_len} = {`OD_ADDR_W'd1, `OD_ADDR_W'd1};
					`OD_ID_W'd3: {ent_off, ent_len} = {`OD_ADDR_W'd2, `OD_ADDR_W'd2};
					default:     ent_ok = 1'b0;
				endcase
			od_pkg::SCHED_MGMT:
				case (i_subidx)
					`OD_ID_W'd0:  {ent_off, ent_len} = {`OD_ADDR_W'd0, `OD_ADDR_W'd24};
					`OD_ID_W'd1:  {ent_off, ent_len} = {`OD_ADDR_W'd0, `OD_ADDR_W'd1};
					`OD_ID_W'd2:  {ent_off, ent_len} = {`OD_ADDR_W'd1, `OD_ADDR_W'd1};
					`OD_ID_W'd3:  {ent_off, ent_len} = {`OD_ADDR_W'd2, `OD_ADDR_W'd2};
					`OD_ID_W'd4:  {ent_off, ent_len} = {`OD_ADDR_W'd4, `OD_ADDR_W'd2};
					`OD_ID_W'd5:  {ent_off, ent_len} = {`OD_ADDR_W'd6, `OD_ADDR_W'd1};
					`OD_ID_W'd6:  {ent_off, ent_len} = {`OD_ADDR_W'd7, `OD_ADDR_W'd1};
					`OD_ID_W'd7:  {ent_off, ent_len} = {`OD_ADDR_W'd8, `OD_ADDR_W'd2};
					`OD_ID_W'd8:  {ent_off, ent_len} = {`OD_ADDR_W'd10, `OD_ADDR_W'd1};
					`OD_ID_W'd9:  {ent_off, ent_len} = {`OD_ADDR_W'd11, `OD_ADDR_W'd1};
					`OD_ID_W'd10: {ent_off, ent_len} = {`OD_ADDR_W'd12, `OD_ADDR_W'd1};
					`OD_ID_W'd11: {ent_off, ent_len} = {`OD_ADDR_W'd13, `OD_ADDR_W'd1};
					`OD_ID_W'd12: {ent_off, ent_len} = {`OD_ADDR_W'd14, `OD_ADDR_W'd2};
					`OD_ID_W'd13: {ent_off, ent_len} = {`OD_ADDR_W'd16, `OD_ADDR_W'd2};
					`OD_ID_W'd14: {ent_off, ent_len} = {`OD_ADDR_W'd18, `OD_ADDR_W'd2};
					`OD_ID_W'd15: {ent_off, ent_len} = {`OD_ADDR_W'd20, `OD_ADDR_W'd1};
					`OD_ID_W'd16: {ent_off, ent_len} = {`OD_ADDR_W'd21, `OD_ADDR_W'd1};
					`OD_ID_W'd17: {ent_off, ent_len} = {`OD_ADDR_W'd22, `OD_ADDR_W'd1};
					`OD_ID_W'd18: {ent_off, ent_len} = {`OD_ADDR_W'd23, `OD_ADDR_W'd1};
					default:      ent_ok = 1'b0;
				endcase
			od_pkg::LINK_LOCAL_UP:
				case (i_subidx)
					`OD_ID_W'd0: ent_len = i_frt_linknum_up[`OD_ADDR_W-1:0];   // live link count
					`OD_ID_W'd1: {ent_off, ent_len} = {`OD_ADDR_W'd0, `OD_ADDR_W'd2};
					`OD_ID_W'd2: {ent_off, ent_len} = {`OD_ADDR_W'd2, `OD_ADDR_W'd1};
					`OD_ID_W'd3: {ent_off, ent_len} = {`OD_ADDR_W'd3, `OD_ADDR_W'd1};
					`OD_ID_W'd4: {ent_off, ent_len} = {`OD_ADDR_W'd4, `OD_ADDR_W'd1};
					`OD_ID_W'd5: {ent_off, ent_len} = {`OD_ADDR_W'd5, `OD_ADDR_W'd1};
					`OD_ID_W'd6: {ent_off, ent_len} = {`OD_ADDR_W'd6, `OD_ADDR_W'd1};
					`OD_ID_W'd7: {ent_off, ent_len} = {`OD_ADDR_W'd7, `OD_ADDR_W'd1};
					default:     ent_ok = 1'b0;
				endcase
			od_pkg::DEV_PROP_UP:
				case (i_subidx)
					`OD_ID_W'd0: ent_len = i_device_num_up[`OD_ADDR_W-1:0];
					`OD_ID_W'd1: {ent_off, ent_len} = {`OD_ADDR_W'd0, `OD_ADDR_W'd2};
					`OD_ID_W'd2: {ent_off, ent_len} = {`OD_ADDR_W'd2, `OD_ADDR_W'd3};
					`OD_ID_W'd3: {ent_off, ent_len} = {`OD_ADDR_W'd5, `OD_ADDR_W'd2};
					`OD_ID_W'd4: {ent_off, ent_len} = {`OD_ADDR_W'd7, `OD_ADDR_W'd1};
					`OD_ID_W'd5: {ent_off, ent_len} = {`OD_ADDR_W'd8, `OD_ADDR_W'd1};
					default:     ent_ok = 1'b0;
				endcase
			default: ent_ok = 1'b0;   // UNKNOWN
		endcase

		// tables of single-byte entries, offset is subindex minus one
		if (ones_cnt != '0)
		begin
			if (i_subidx == '0)
				ent_len = (i_class == od_pkg::LINK_NET_UP) ?
					i_frt_linknum_net_up[`OD_ADDR_W-1:0] : ones_cnt[`OD_ADDR_W-1:0];
			else if (i_subidx <= ones_cnt)
			begin
				ent_off = i_subidx[`OD_ADDR_W-1:0] - `OD_ADDR_W'd1;
				ent_len = `OD_ADDR_W'd1;
			end
			else
				ent_ok = 1'b0;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_offset <= '0;
			o_len <= '0;
			o_sub_ok <= 1'b1;   // idle slot reads as clean
		end
		else
		begin
			o_offset <= ent_off;
			o_len <= ent_len;
			o_sub_ok <= ent_ok;
		end
	end

endmodule

`default_nettype wire

// File: source/od_result_merge.sv
/* result merge stage */
`timescale 1ns/100ps
`default_nettype none

`include "od_defs.svh"

module od_result_merge
(
	input  wire              i_clk,
	input  wire              i_rst_n,
	input  od_pkg::od_addr_t i_base,
	input  od_pkg::od_addr_t i_offset,
	input  od_pkg::od_addr_t i_len,
	input  wire              i_obj_known,
	input  wire              i_sub_ok,
	output od_pkg::od_addr_t o_base_addr,
	output od_pkg::od_addr_t o_offset_addr,
	output od_pkg::od_addr_t o_offset_len,
	output logic             o_error
);

	logic hit;

	assign hit = i_obj_known && i_sub_ok;   // both halves resolved

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_base_addr <= '0;
			o_offset_addr <= '0;
			o_offset_len <= '0;
			o_error <= 1'b0;
		end
		else if (hit)
		begin
			o_base_addr <= i_base;
			o_offset_addr <= i_offset;
			o_offset_len <= i_len;
			o_error <= 1'b0;
		end
		else
		begin
			// bad object or subindex
			o_base_addr <= `OD_ADDR_INVALID;
			o_offset_addr <= `OD_ADDR_INVALID;
			o_offset_len <= '0;
			o_error <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/od_lookup_top.sv
/* object dictionary address resolver */
`timescale 1ns/100ps
`default_nettype none

module od_lookup_top
(
	input  wire              i_clk,
	input  wire              i_rst_n,
	input  od_pkg::od_id_t   i_dobjid,
	input  od_pkg::od_id_t   i_subidx,
	input  od_pkg::od_id_t   i_frt_linknum_up,
	input  od_pkg::od_id_t   i_frt_linknum_net_up,
	input  od_pkg::od_id_t   i_device_num_up,
	output od_pkg::od_addr_t o_base_addr,
	output od_pkg::od_addr_t o_offset_addr,
	output od_pkg::od_addr_t o_offset_len,
	output logic             o_error
);

	od_pkg::od_class_e obj_class;
	od_pkg::od_id_t    obj_index;
	od_pkg::od_addr_t  stg_base;     // stage 1 results
	od_pkg::od_addr_t  stg_off;
	od_pkg::od_addr_t  stg_len;
	logic              stg_known;
	logic              stg_sub_ok;

	od_obj_classify classify_i (
		.i_dobjid (i_dobjid),
		.o_class  (obj_class),
		.o_index  (obj_index)
	);

	od_base_addr base_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_class     (obj_class),
		.i_index     (obj_index),
		.o_base      (stg_base),
		.o_obj_known (stg_known)
	);

	od_entry_table entry_i (
		.i_clk                (i_clk),
		.i_rst_n              (i_rst_n),
		.i_class              (obj_class),
		.i_subidx             (i_subidx),
		.i_frt_linknum_up     (i_frt_linknum_up),
		.i_frt_linknum_net_up (i_frt_linknum_net_up),
		.i_device_num_up      (i_device_num_up),
		.o_offset             (stg_off),
		.o_len                (stg_len),
		.o_sub_ok             (stg_sub_ok)
	);

	od_result_merge merge_i (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_base        (stg_base),
		.i_offset      (stg_off),
		.i_len         (stg_len),
		.i_obj_known   (stg_known),
		.i_sub_ok      (stg_sub_ok),
		.o_base_addr   (o_base_addr),
		.o_offset_addr (o_offset_addr),
		.o_offset_len  (o_offset_len),
		.o_error       (o_error)
	);

endmodule

`default_nettype wire

// File: tb/od_vectors.svh
/* lookup test vectors */
`ifndef OD_VECTORS_SVH
`define OD_VECTORS_SVH

// kept fixed objects, entry lengths from subindex 1 upward, zero pads a row
localparam int N_FIXED = 11;
localparam int FIX_ID [N_FIXED] = '{0, 1, 2, 3, 4, 5, 6, 9, 10, 11, 12};
localparam int FIX_BASE [N_FIXED] = '{0, 0, 2, 54, 75, 79, 103, 113, 118, 123, 128};
localparam int FIX_LENS [N_FIXED][18] = '{
	'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},     // whole dictionary
	'{1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
	'{1, 1, 16, 16, 2, 2, 2, 2, 3, 1, 2, 1, 1, 1, 1, 0, 0, 0},  // device descriptor
	'{1, 1, 2, 2, 2, 2, 2, 2, 4, 3, 0, 0, 0, 0, 0, 0, 0, 0},
	'{1, 1, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
	'{1, 1, 2, 2, 1, 1, 2, 1, 1, 1, 1, 2, 2, 2, 1, 1, 1, 1},     // schedule, full row
	'{1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
	'{1, 1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
	'{1, 1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
	'{1, 1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
	'{1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}
};
localparam int DICT_SPAN = 144;

// link ranges in order local-up, net-up, device-properties-up
localparam int LINK_START [3] = '{6000, 7000, 8000};
localparam int LINK_BASE [3] = '{'h100, 'h300, 'h400};
localparam int LINK_SCALE [3] = '{8, 4, 9};    // object size in bytes
localparam int LINK_LENS [3][8] = '{
	'{2, 1, 1, 1, 1, 1, 1, 0},
	'{1, 1, 1, 1, 0, 0, 0, 0},
	'{2, 3, 2, 1, 1, 0, 0, 0}
};

// dropped ids, range edges and subindices far past the table end
localparam int N_ERR = 12;
localparam int ERR_ID [N_ERR] = '{7, 8, 13, 14, 15, 9500, 12000, 5999, 9000, 65535, 2, 6};
localparam int ERR_SUB [N_ERR] = '{0, 1, 0, 0, 3, 0, 2, 0, 0, 0, 65535, 4096};

`endif

// File: tb/tb_od_lookup.sv
/* object dictionary lookup testbench */
`timescale 1ns/100ps
`default_nettype none

module tb_od_lookup;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY = 10;   // after the rising edge
	localparam int N_RAND = 30;

	`include "od_vectors.svh"

	typedef struct {
		od_pkg::od_id_t   id;
		od_pkg::od_id_t   sub;
		od_pkg::od_id_t   cnt_up;
		od_pkg::od_id_t   cnt_net;
		od_pkg::od_id_t   cnt_dev;
		od_pkg::od_addr_t base;
		od_pkg::od_addr_t off;
		od_pkg::od_addr_t len;
		logic             err;
	} vec_t;

	logic             i_clk;
	logic             i_rst_n;
	od_pkg::od_id_t   i_dobjid;
	od_pkg::od_id_t   i_subidx;
	od_pkg::od_id_t   i_frt_linknum_up;
	od_pkg::od_id_t   i_frt_linknum_net_up;
	od_pkg::od_id_t   i_device_num_up;
	od_pkg::od_addr_t o_base_addr;
	od_pkg::od_addr_t o_offset_addr;
	od_pkg::od_addr_t o_offset_len;
	logic             o_error;

	logic [31:0] lfsr;
	vec_t        fixed_q [$];
	vec_t        link_q [$];
	vec_t        exp_q [$];     // requests still in the pipeline
	int unsigned n_vectors;

	od_lookup_top dut_i (
		.i_clk                (i_clk),
		.i_rst_n              (i_rst_n),
		.i_dobjid             (i_dobjid),
		.i_subidx             (i_subidx),
		.i_frt_linknum_up     (i_frt_linknum_up),
		.i_frt_linknum_net_up (i_frt_linknum_net_up),
		.i_device_num_up      (i_device_num_up),
		.o_base_addr          (o_base_addr),
		.o_offset_addr        (o_offset_addr),
		.o_offset_len         (o_offset_len),
		.o_error              (o_error)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic vec_t make_vec(input int id, input int sub, input int base,
		input int off, input int len, input logic err);
		vec_t v;
		v.id = od_pkg::od_id_t'(id);
		v.sub = od_pkg::od_id_t'(sub);
		v.cnt_up = od_pkg::od_id_t'(take_bits(16));   // counts random on every row
		v.cnt_net = od_pkg::od_id_t'(take_bits(16));
		v.cnt_dev = od_pkg::od_id_t'(take_bits(16));
		v.base = err ? 12'hfff : od_pkg::od_addr_t'(base % 4096);
		v.off = err ? 12'hfff : od_pkg::od_addr_t'(off);
		v.len = err ? 12'h000 : od_pkg::od_addr_t'(len);
		v.err = err;
		return v;
	endfunction

	task automatic build_fixed();
		int r;
		int k;
		int n;
		int off;
		int total;
		for (r = 0; r < N_FIXED; r++)
		begin
			n = 0;
			total = 0;
			for (k = 0; k < 18; k++)
			begin
				if (FIX_LENS[r][k] != 0)
				begin
					total += FIX_LENS[r][k];
					n++;
				end
			end
			if (FIX_ID[r] == 0)
				total = DICT_SPAN;   // only subindex 0 there
			fixed_q.push_back(make_vec(FIX_ID[r], 0, FIX_BASE[r], 0, total, 1'b0));
			off = 0;
			for (k = 1; k <= n; k++)
			begin
				fixed_q.push_back(make_vec(FIX_ID[r], k, FIX_BASE[r], off,
					FIX_LENS[r][k - 1], 1'b0));
				off += FIX_LENS[r][k - 1];
			end
			fixed_q.push_back(make_vec(FIX_ID[r], n + 1, 0, 0, 0, 1'b1));   // one past end
		end
		for (r = 0; r < N_ERR; r++)
			fixed_q.push_back(make_vec(ERR_ID[r], ERR_SUB[r], 0, 0, 0, 1'b1));
	endtask

	task automatic build_link();
		int   i;
		int   j;
		int   r;
		int   idx;
		int   k;
		int   n;
		int   off;
		int   len;
		vec_t v;
		for (i = 0; i < N_RAND; i++)
		begin
			r = i % 3;
			idx = int'(take_bits(10));
			if (idx >= 1000)
				idx -= 1000;
			if (i < 3)
				k = 0;   // first pass over the ranges reads the live counts
			else
				k = int'(take_bits(3));
			n = 0;
			for (j = 0; j < 8; j++)
				if (LINK_LENS[r][j] != 0)
					n++;
			off = 0;
			len = 0;
			if (k >= 1 && k <= n)
			begin
				for (j = 0; j < k - 1; j++)
					off += LINK_LENS[r][j];
				len = LINK_LENS[r][k - 1];
			end
			v = make_vec(LINK_START[r] + idx, k, idx * LINK_SCALE[r] + LINK_BASE[r],
				off, len, k > n);
			if (k == 0)
				v.len = (r == 0) ? v.cnt_up[11:0] : (r == 1) ? v.cnt_net[11:0] : v.cnt_dev[11:0];
			link_q.push_back(v);
		end
	endtask

	task automatic report_failure();
		$display("Test failures found");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic check_addr(input string name, input string tag,
		input od_pkg::od_addr_t got, input od_pkg::od_addr_t exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got %h expected %h (%s)", name, got, exp, tag);
			report_failure();
		end
	endtask

	task automatic check_flag(input string name, input string tag, input logic got,
		input logic exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got %h expected %h (%s)", name, got, exp, tag);
			report_failure();
		end
	endtask

	task automatic check_result(input vec_t e);
		string tag;
		tag = $sformatf("id %h sub %h", e.id, e.sub);
		check_addr("o_base_addr", tag, o_base_addr, e.base);
		check_addr("o_offset_addr", tag, o_offset_addr, e.off);
		check_addr("o_offset_len", tag, o_offset_len, e.len);
		check_flag("o_error", tag, o_error, e.err);
	endtask

	task automatic check_idle();
		check_addr("o_base_addr", "idle", o_base_addr, 12'h000);
		check_addr("o_offset_addr", "idle", o_offset_addr, 12'h000);
		check_addr("o_offset_len", "idle", o_offset_len, 12'h000);
		check_flag("o_error", "idle", o_error, 1'b0);
	endtask

	task automatic drive_request(input vec_t v);
		i_dobjid = v.id;
		i_subidx = v.sub;
		i_frt_linknum_up = v.cnt_up;
		i_frt_linknum_net_up = v.cnt_net;
		i_device_num_up = v.cnt_dev;
	endtask

	initial
	begin : stimulus
		vec_t cur;
		logic pick_link;
		i_rst_n = 1'b0;
		i_dobjid = '0;
		i_subidx = '0;
		i_frt_linknum_up = '0;
		i_frt_linknum_net_up = '0;
		i_device_num_up = '0;
		lfsr = 32'h4b9b_07c0;
		pick_link = 1'b1;
		build_fixed();
		build_link();
		n_vectors = fixed_q.size() + link_q.size();
		repeat (2) @(posedge i_clk);
		#DRIVE_DLY;
		i_rst_n = 1'b1;
		// one request per cycle while link and fixed rows take turns
		while (fixed_q.size() + link_q.size() > 0)
		begin
			if (exp_q.size() == 2)
				check_result(exp_q.pop_front());
			else
				check_idle();   // nothing has left the pipeline yet
			if (link_q.size() > 0 && (fixed_q.size() == 0 || pick_link))
				cur = link_q.pop_front();
			else
				cur = fixed_q.pop_front();
			pick_link = !pick_link;
			drive_request(cur);
			exp_q.push_back(cur);
			@(posedge i_clk);
			#DRIVE_DLY;
		end
		while (exp_q.size() > 0)
		begin
			check_result(exp_q.pop_front());
			@(posedge i_clk);
			#DRIVE_DLY;
		end
		$display("All tests passed!");
		$finish;
	end

	initial
	begin : watchdog
		#1;
		#((n_vectors + 20) * CLK_PERIOD);
		$display("timeout, the request sequence did not complete in time");
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
+incdir+tb
source/od_pkg.sv
source/od_obj_classify.sv
source/od_base_addr.sv
source/od_entry_table.sv
source/od_result_merge.sv
source/od_lookup_top.sv
tb/tb_od_lookup.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the object dictionary lookup testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_od_lookup -o sim_od_lookup

output=$(./obj_dir/sim_od_lookup 2>&1 || true)
echo "$output"

if grep -qF "All tests passed!" <<< "$output"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
